// ==== compile.f ====
+incdir+include
source/accel_pkg.sv
source/layer_config_regs.sv
source/dispatch_ctrl.sv
source/result_collector.sv
source/result_buffer.sv
source/accel_top.sv
tb/tb_clock_gen.sv
tb/accel_top_tb.sv

// ==== include/accel_settings.svh ====
`ifndef ACCEL_SETTINGS_SVH
`define ACCEL_SETTINGS_SVH

// widths
`define ACC_INSTR_BITS 105
`define ACC_OP_BITS 3
`define ACC_ADDR_BITS 10
`define ACC_DIM_BITS 8
`define ACC_WORD_BITS 16

// words per result buffer
`define ACC_BUF_DEPTH 1024

// instruction field low bits, bits 68 to 101 unused here
`define ACC_OP_LSB 102
`define ACC_A_SRC_LSB 58
`define ACC_A_CHANNEL_LSB 50
`define ACC_A_ROW_LSB 42
`define ACC_A_COL_LSB 34
`define ACC_B_SRC_LSB 24
`define ACC_B_CHANNEL_LSB 16
`define ACC_B_ROW_LSB 8
`define ACC_B_COL_LSB 0

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert -f compile.f --top-module accel_top_tb &&
    ./obj_dir/Vaccel_top_tb | tee /dev/stderr | grep "Simulation PASSED" > /dev/null &&
    echo "run passed" ||
    { echo "run failed"; exit 1; }

// ==== source/accel_pkg.sv ====
`include "accel_settings.svh"

package accel_pkg;

    typedef logic [`ACC_INSTR_BITS-1:0] instr_t;
    typedef logic [`ACC_ADDR_BITS-1:0] word_addr_t;
    typedef logic [`ACC_DIM_BITS-1:0] dim_t;
    typedef logic [`ACC_WORD_BITS-1:0] word_t;
    typedef logic [`ACC_OP_BITS-1:0] op_t;

    // layer opcodes, 3 to 7 are illegal
    typedef enum op_t {
        op_load = 3'd0,
        op_conv = 3'd1,
        op_mat  = 3'd2
    } accel_op_e;

    typedef enum logic [1:0] {
        st_idle,
        st_wait_both,
        st_wait_sys
    } dispatch_state_e;

endpackage

// ==== source/accel_top.sv ====
`timescale 1ns/1ps

module accel_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  instr_valid,
    input  accel_pkg::instr_t     instr,
    input  accel_pkg::word_addr_t data_total,
    input  logic                  uni_ack,
    input  logic                  sys_ack,
    input  logic                  sys_done,
    input  logic                  result_valid,
    input  accel_pkg::word_t      result_uni,
    input  accel_pkg::word_t      result_wei,
    input  accel_pkg::word_addr_t rd_addr,
    output logic                  ack,
    output logic                  uni_cfg_valid,
    output logic                  sys_cfg_valid,
    output accel_pkg::op_t        cfg_op,
    output accel_pkg::word_addr_t a_src_addr,
    output accel_pkg::dim_t       a_channel,
    output accel_pkg::dim_t       a_row,
    output accel_pkg::dim_t       a_col,
    output accel_pkg::word_addr_t b_src_addr,
    output accel_pkg::dim_t       b_channel,
    output accel_pkg::dim_t       b_row,
    output accel_pkg::dim_t       b_col,
    output logic                  done,
    output accel_pkg::word_t      rd_uni,
    output accel_pkg::word_t      rd_wei
);

    accel_pkg::op_t        instr_op;
    accel_pkg::op_t        held_op;
    logic                  load_fields;
    logic                  load_op;
    logic                  wr_en;
    accel_pkg::word_addr_t wr_addr;
    accel_pkg::word_t      wr_uni;
    accel_pkg::word_t      wr_wei;

    layer_config_regs u_layer_config_regs (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr),
        .load_fields (load_fields),
        .load_op     (load_op),
        .instr_op    (instr_op),
        .held_op     (held_op),
        .a_src_addr  (a_src_addr),
        .a_channel   (a_channel),
        .a_row       (a_row),
        .a_col       (a_col),
        .b_src_addr  (b_src_addr),
        .b_channel   (b_channel),
        .b_row       (b_row),
        .b_col       (b_col)
    );

    dispatch_ctrl u_dispatch_ctrl (
        .clk           (clk),
        .rst           (rst),
        .instr_valid   (instr_valid),
        .instr_op      (instr_op),
        .held_op       (held_op),
        .uni_ack       (uni_ack),
        .sys_ack       (sys_ack),
        .sys_done      (sys_done),
        .ack           (ack),
        .uni_cfg_valid (uni_cfg_valid),
        .sys_cfg_valid (sys_cfg_valid),
        .cfg_op        (cfg_op),
        .load_fields   (load_fields),
        .load_op       (load_op)
    );

    result_collector u_result_collector (
        .clk          (clk),
        .rst          (rst),
        .result_valid (result_valid),
        .result_uni   (result_uni),
        .result_wei   (result_wei),
        .data_total   (data_total),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_uni       (wr_uni),
        .wr_wei       (wr_wei),
        .done         (done)
    );

    result_buffer u_buf_uni (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_uni),
        .rd_addr (rd_addr),
        .rd_data (rd_uni)
    );

    result_buffer u_buf_wei (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_wei),
        .rd_addr (rd_addr),
        .rd_data (rd_wei)
    );

endmodule

// ==== source/dispatch_ctrl.sv ====
`timescale 1ns/1ps

module dispatch_ctrl (
    input  logic           clk,
    input  logic           rst,
    input  logic           instr_valid,
    input  accel_pkg::op_t instr_op,
    input  accel_pkg::op_t held_op,
    input  logic           uni_ack,
    input  logic           sys_ack,
    input  logic           sys_done,
    output logic           ack,
    output logic           uni_cfg_valid,
    output logic           sys_cfg_valid,
    output accel_pkg::op_t cfg_op,
    output logic           load_fields,
    output logic           load_op
);

    accel_pkg::dispatch_state_e state;
    logic                       legal;
    logic                       accept;

    assign legal = (instr_op == accel_pkg::op_load) ||
                   (instr_op == accel_pkg::op_conv) ||
                   (instr_op == accel_pkg::op_mat);

    assign accept      = instr_valid && legal && (state == accel_pkg::st_idle);
    assign load_fields = accept && (instr_op == accel_pkg::op_load);
    assign load_op     = accept && (instr_op != accel_pkg::op_load);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state         <= accel_pkg::st_idle;
            ack           <= 1'b0;
            uni_cfg_valid <= 1'b0;
            sys_cfg_valid <= 1'b0;
            cfg_op        <= accel_pkg::op_load;
        end else begin
            // valids are single-cycle pulses
            ack           <= 1'b0;
            uni_cfg_valid <= 1'b0;
            sys_cfg_valid <= 1'b0;
            case (state)
                accel_pkg::st_idle: begin
                    if (accept) begin
                        ack           <= 1'b1;
                        uni_cfg_valid <= 1'b1;
                        sys_cfg_valid <= 1'b1;
                        cfg_op        <= instr_op;
                        state         <= accel_pkg::st_wait_both;
                    end else if (sys_done) begin
                        // array alone gets the stored compute op
                        sys_cfg_valid <= 1'b1;
                        cfg_op        <= held_op;
                        state         <= accel_pkg::st_wait_sys;
                    end
                end
                accel_pkg::st_wait_both: begin
                    if (uni_ack && sys_ack) begin
                        state <= accel_pkg::st_idle;
                    end
                end
                accel_pkg::st_wait_sys: begin
                    if (sys_ack) begin
                        state <= accel_pkg::st_idle;
                    end
                end
                default: begin
                    state <= accel_pkg::st_idle;
                end
            endcase
        end
    end

    a_ack_single: assert property (@(posedge clk) disable iff (!rst) ack |=> !ack)
        else $error("ack held for two cycles");

    a_ack_cfg: assert property (@(posedge clk) disable iff (!rst) ack |-> uni_cfg_valid)
        else $error("ack without uni_cfg_valid");

    a_uni_accept: assert property (@(posedge clk) disable iff (!rst)
        uni_cfg_valid |-> $past(accept))
        else $error("uni_cfg_valid without an accepted instruction");

endmodule

// ==== source/layer_config_regs.sv ====
`timescale 1ns/1ps
`include "accel_settings.svh"

module layer_config_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  accel_pkg::instr_t     instr,
    input  logic                  load_fields,
    input  logic                  load_op,
    output accel_pkg::op_t        instr_op,
    output accel_pkg::op_t        held_op,
    output accel_pkg::word_addr_t a_src_addr,
    output accel_pkg::dim_t       a_channel,
    output accel_pkg::dim_t       a_row,
    output accel_pkg::dim_t       a_col,
    output accel_pkg::word_addr_t b_src_addr,
    output accel_pkg::dim_t       b_channel,
    output accel_pkg::dim_t       b_row,
    output accel_pkg::dim_t       b_col
);

    // raw field slices
    accel_pkg::word_addr_t in_a_src;
    accel_pkg::dim_t       in_a_channel;
    accel_pkg::dim_t       in_a_row;
    accel_pkg::dim_t       in_a_col;
    accel_pkg::word_addr_t in_b_src;
    accel_pkg::dim_t       in_b_channel;
    accel_pkg::dim_t       in_b_row;
    accel_pkg::dim_t       in_b_col;

    assign instr_op     = instr[`ACC_OP_LSB +: `ACC_OP_BITS];
    assign in_a_src     = instr[`ACC_A_SRC_LSB +: `ACC_ADDR_BITS];
    assign in_a_channel = instr[`ACC_A_CHANNEL_LSB +: `ACC_DIM_BITS];
    assign in_a_row     = instr[`ACC_A_ROW_LSB +: `ACC_DIM_BITS];
    assign in_a_col     = instr[`ACC_A_COL_LSB +: `ACC_DIM_BITS];
    assign in_b_src     = instr[`ACC_B_SRC_LSB +: `ACC_ADDR_BITS];
    assign in_b_channel = instr[`ACC_B_CHANNEL_LSB +: `ACC_DIM_BITS];
    assign in_b_row     = instr[`ACC_B_ROW_LSB +: `ACC_DIM_BITS];
    assign in_b_col     = instr[`ACC_B_COL_LSB +: `ACC_DIM_BITS];

    // layer fields, shared by both engines
    always_ff @(posedge clk) begin
        if (load_fields) begin
            a_src_addr <= in_a_src;
            a_channel  <= in_a_channel;
            a_row      <= in_a_row;
            a_col      <= in_a_col;
            b_src_addr <= in_b_src;
            b_channel  <= in_b_channel;
            b_row      <= in_b_row;
            b_col      <= in_b_col;
        end
    end

    // compute op replayed on sys_done
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            held_op <= accel_pkg::op_load;
        end else if (load_op) begin
            held_op <= instr_op;
        end
    end

endmodule

// ==== source/result_buffer.sv ====
`timescale 1ns/1ps
`include "accel_settings.svh"

module result_buffer (
    input  logic                  clk,
    input  logic                  wr_en,
    input  accel_pkg::word_addr_t wr_addr,
    input  accel_pkg::word_t      wr_data,
    input  accel_pkg::word_addr_t rd_addr,
    output accel_pkg::word_t      rd_data
);

    accel_pkg::word_t mem [`ACC_BUF_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // one cycle read latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== source/result_collector.sv ====
`timescale 1ns/1ps

module result_collector (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  result_valid,
    input  accel_pkg::word_t      result_uni,
    input  accel_pkg::word_t      result_wei,
    input  accel_pkg::word_addr_t data_total,
    output logic                  wr_en,
    output accel_pkg::word_addr_t wr_addr,
    output accel_pkg::word_t      wr_uni,
    output accel_pkg::word_t      wr_wei,
    output logic                  done
);

    accel_pkg::word_addr_t last_addr;

    assign last_addr = accel_pkg::word_addr_t'(data_total - 1'b1);

    // address starts at all ones so the first result lands at 0
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr_en   <= 1'b0;
            wr_addr <= '1;
            done    <= 1'b0;
        end else if (result_valid) begin
            wr_en   <= 1'b1;
            wr_addr <= accel_pkg::word_addr_t'(wr_addr + 1'b1);
        end else begin
            wr_en <= 1'b0;
            done  <= (wr_addr == last_addr);
        end
    end

    always_ff @(posedge clk) begin
        if (result_valid) begin
            wr_uni <= result_uni;
            wr_wei <= result_wei;
        end
    end

    a_wr_after_result: assert property (@(posedge clk) disable iff (!rst)
        $rose(wr_en) |-> $past(result_valid))
        else $error("write enable rose without a result");

endmodule

// ==== tb/accel_top_tb.sv ====
`timescale 1ns/1ps
`include "accel_settings.svh"

module accel_top_tb;

    localparam int ROWS = 6;
    localparam int FIELD_BITS = `ACC_A_SRC_LSB + `ACC_ADDR_BITS;
    localparam int TIMEOUT = 20;

    logic                  clk, rst, instr_valid, uni_ack, sys_ack, sys_done, result_valid;
    logic                  ack, uni_cfg_valid, sys_cfg_valid, done;
    accel_pkg::instr_t     instr;
    accel_pkg::op_t        cfg_op;
    accel_pkg::word_addr_t data_total, rd_addr, a_src_addr, b_src_addr;
    accel_pkg::word_t      result_uni, result_wei, rd_uni, rd_wei;
    accel_pkg::dim_t       a_channel, a_row, a_col, b_channel, b_row, b_col;

    // rows: opcode, expected cfg_op, acked, replayed after sys_done
    accel_pkg::op_t tbl_op [ROWS]     = '{3'd0, 3'd1, 3'd2, 3'd3, 3'd0, 3'd2};
    accel_pkg::op_t tbl_exp_op [ROWS] = '{3'd0, 3'd1, 3'd2, 3'd0, 3'd0, 3'd2};
    logic tbl_acked [ROWS]            = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1};
    logic tbl_replay [ROWS]           = '{1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1};
    accel_pkg::instr_t     tbl_instr [ROWS];
    logic [FIELD_BITS-1:0] tbl_fields [ROWS];

    integer seed = 32'h9d1c_9994;
    int errors = 0;
    int timeouts = 0;
    int ack_total = 0;
    int uni_total = 0;
    int sys_total = 0;
    accel_pkg::word_t sent_uni [$];
    accel_pkg::word_t sent_wei [$];

    tb_clock_gen u_clock_gen (.clk(clk), .rst(rst));

    accel_top u_accel_top (.*);

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("Error: %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    task automatic wait_engine_ack(input string tag);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!sys_ack && cycles < TIMEOUT);
        assert (sys_ack) else begin
            timeouts++;
            $display("%s: the engine never acknowledged the configuration", tag);
        end
    endtask

    task automatic replay_op(input int i, input string tag);
        int cycles;
        @(negedge clk);
        sys_done = 1'b1;
        cycles = 0;
        do begin
            @(negedge clk);
            sys_done = 1'b0;
            cycles++;
        end while (!sys_cfg_valid && cycles < TIMEOUT);
        assert (sys_cfg_valid) else begin
            timeouts++;
            $display("%s: sys_done gave no sys_cfg_valid", tag);
        end
        check_value({tag, " replay uni_cfg_valid"}, 128'(0), 128'(uni_cfg_valid));
        check_value({tag, " replay cfg_op"}, 128'(tbl_exp_op[i]), 128'(cfg_op));
        wait_engine_ack(tag);
    endtask

    task automatic apply_row(input int i);
        string tag;
        int cycles;
        int ack0;
        int uni0;
        int sys0;
        logic [FIELD_BITS-1:0] fields;
        tag = $sformatf("row %0d op %0d", i, tbl_op[i]);
        @(posedge clk);
        ack0 = ack_total;
        uni0 = uni_total;
        sys0 = sys_total;
        @(negedge clk);
        instr = tbl_instr[i];
        instr_valid = 1'b1;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!ack && cycles < TIMEOUT);
        // host drops valid once ack is seen
        instr_valid = 1'b0;
        fields = {a_src_addr, a_channel, a_row, a_col, b_src_addr, b_channel, b_row, b_col};
        check_value({tag, " fields"}, 128'(tbl_fields[i]), 128'(fields));
        if (tbl_acked[i]) begin
            assert (ack) else begin
                timeouts++;
                $display("%s: instruction was never acknowledged", tag);
            end
            check_value({tag, " uni_cfg_valid"}, 128'(1), 128'(uni_cfg_valid));
            check_value({tag, " sys_cfg_valid"}, 128'(1), 128'(sys_cfg_valid));
            check_value({tag, " cfg_op"}, 128'(tbl_exp_op[i]), 128'(cfg_op));
            wait_engine_ack(tag);
            if (tbl_replay[i]) begin
                replay_op(i, tag);
            end
        end
        @(posedge clk);
        check_value({tag, " ack count"}, 128'(tbl_acked[i]), 128'(ack_total - ack0));
        check_value({tag, " uni cfg count"}, 128'(tbl_acked[i]), 128'(uni_total - uni0));
        check_value({tag, " sys cfg count"}, 128'(int'(tbl_acked[i]) + int'(tbl_replay[i])),
                    128'(sys_total - sys0));
    endtask

    // engine model, answers two cycles after each configuration
    initial begin
        logic both;
        uni_ack = 1'b0;
        sys_ack = 1'b0;
        forever begin
            @(negedge clk);
            if (sys_cfg_valid) begin
                both = uni_cfg_valid;
                repeat (2) @(negedge clk);
                uni_ack = both;
                sys_ack = 1'b1;
                @(negedge clk);
                uni_ack = 1'b0;
                sys_ack = 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (ack) ack_total++;
        if (uni_cfg_valid) uni_total++;
        if (sys_cfg_valid) sys_total++;
    end

    initial begin
        logic [127:0] rnd;
        logic [FIELD_BITS-1:0] last_load;
        int cycles;
        instr_valid = 1'b0;
        instr = '0;
        sys_done = 1'b0;
        result_valid = 1'b0;
        result_uni = '0;
        result_wei = '0;
        rd_addr = '0;
        rnd[31:0] = $random(seed);
        data_total = accel_pkg::word_addr_t'(16 + rnd[4:0]);
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!rst && cycles < TIMEOUT);
        assert (rst) else begin
            timeouts++;
            $display("reset was never released");
        end
        @(negedge clk);
        check_value("outputs after reset", 128'(0), 128'({ack, uni_cfg_valid, sys_cfg_valid, done}));
        // WB bits 68 to 101 get random filler as well
        last_load = '0;
        for (int i = 0; i < ROWS; i++) begin
            rnd = {$random(seed), $random(seed), $random(seed), $random(seed)};
            tbl_instr[i] = {tbl_op[i], rnd[`ACC_OP_LSB-1:0]};
            if (tbl_op[i] == accel_pkg::op_load) begin
                last_load = rnd[FIELD_BITS-1:0];
            end
            tbl_fields[i] = last_load;
        end
        for (int i = 0; i < ROWS; i++) begin
            apply_row(i);
        end
        for (int k = 0; k < int'(data_total); k++) begin
            @(negedge clk);
            check_value("done before last result", 128'(0), 128'(done));
            rnd[63:0] = {$random(seed), $random(seed)};
            result_valid = 1'b1;
            result_uni = rnd[15:0];
            result_wei = rnd[31:16];
            sent_uni.push_back(rnd[15:0]);
            sent_wei.push_back(rnd[31:16]);
            repeat (int'(rnd[33:32])) begin
                @(negedge clk);
                result_valid = 1'b0;
            end
        end
        @(negedge clk);
        result_valid = 1'b0;
        cycles = 0;
        while (!done && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        assert (done) else begin
            timeouts++;
            $display("done did not rise after the last result");
        end
        for (int a = 0; a < int'(data_total); a++) begin
            @(negedge clk);
            rd_addr = accel_pkg::word_addr_t'(a);
            @(negedge clk);
            check_value($sformatf("read uni %0d", a), 128'(sent_uni[a]), 128'(rd_uni));
            check_value($sformatf("read wei %0d", a), 128'(sent_wei[a]), 128'(rd_wei));
        end
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // reset held for 8 cycles, released on a falling edge
    initial begin
        rst = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
    end

endmodule
